//--- tb/midi_input_vectors.txt
# name mode byte exp_status exp_byte_nr (hex)
# rx, rxbad = low stop bit, tx = send with extra strobe, loop = byte field is the count
rs_90 rx 90 90 00
rs_3c rx 3c 90 01
rs_40 rx 40 90 02
rs_3c_off rx 3c 90 03
rs_00 rx 00 90 04
rs_f7 rx f7 90 05
rs_b0 rx b0 b0 00
rs_07 rx 07 b0 01
bad_stop_55 rxbad 55 b0 01
rx_after_bad rx 3c b0 02
tx_a5 tx a5 00 00
tx_01 tx 01 00 00
tx_80 tx 80 00 00
tx_ff tx ff 00 00
roundtrip loop 14 00 00

//--- midi_uart.f
hdl/midi_timing_pkg.sv
hdl/midi_proto_pkg.sv
hdl/midi_bit_if.sv
hdl/midi_bit_timer.sv
hdl/midi_rx_frame.sv
hdl/midi_status_tracker.sv
hdl/midi_tx_frame.sv
hdl/midi_uart_top.sv
tb/midi_clk_gen.sv
tb/midi_uart_checker.sv
tb/midi_uart_tb.sv

//--- run_midi_uart.sh
#!/bin/sh
# build and run the midi uart testbench with verilator

cd "$(dirname "$0")" || exit 1

log=midi_uart_sim.log

verilator --binary --timing -j 0 --top-module midi_uart_tb -f midi_uart.f -o midi_uart_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/midi_uart_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$log"; then
    exit 0
fi

echo "pass message not found in $log"
exit 1

//--- tb/midi_uart_tb.sv
`timescale 1ns/1ns
`default_nettype none

module midi_uart_tb;

    localparam int bit_clks = midi_timing_pkg::clks_per_bit;

    wire        midi_clk;
    wire        reset_mid_n;
    logic       midi_rxd;
    logic       midi_send_byte;
    logic [7:0] midi_out_data;
    wire        byte_ready;
    wire  [7:0] midi_in_data;
    wire        framing_error;
    wire  [7:0] cur_status;
    wire  [7:0] midibyte_nr;
    wire        midi_txd;
    wire        midi_out_ready;

    bit         abort;
    int         seed;
    logic [7:0] last_rx;
    logic [7:0] model_st;
    logic [7:0] model_nr;

    midi_clk_gen u_clk_gen (
        .midi_clk    (midi_clk),
        .reset_mid_n (reset_mid_n)
    );

    midi_uart_top u_midi_uart_top (
        .midi_clk       (midi_clk),
        .reset_mid_n    (reset_mid_n),
        .midi_rxd       (midi_rxd),
        .byte_ready     (byte_ready),
        .midi_in_data   (midi_in_data),
        .framing_error  (framing_error),
        .cur_status     (cur_status),
        .midibyte_nr    (midibyte_nr),
        .midi_send_byte (midi_send_byte),
        .midi_out_data  (midi_out_data),
        .midi_txd       (midi_txd),
        .midi_out_ready (midi_out_ready)
    );

    midi_uart_checker u_checker (
        .midi_clk       (midi_clk),
        .reset_mid_n    (reset_mid_n),
        .byte_ready     (byte_ready),
        .midi_in_data   (midi_in_data),
        .framing_error  (framing_error),
        .cur_status     (cur_status),
        .midibyte_nr    (midibyte_nr),
        .midi_txd       (midi_txd),
        .midi_out_ready (midi_out_ready)
    );

    task automatic tick();
        @(posedge midi_clk);
        #1;
    endtask

    task automatic drive_frame(input logic [7:0] b, input logic stop);
        logic [9:0] frame;
        int         i;
        frame = {stop, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            midi_rxd = frame[0];
            frame = frame >> 1;
            repeat (bit_clks) tick();
        end
        midi_rxd = 1'b1;
    endtask

    task automatic recv_byte(input string name, input logic [7:0] drive, input bit good,
                             input logic [7:0] exp_data, input logic [7:0] exp_st,
                             input logic [7:0] exp_nr);
        int snap_rx;
        int snap_fe;
        int n;
        snap_rx = u_checker.rx_cnt;
        snap_fe = u_checker.ferr_cnt;
        drive_frame(drive, good);
        n = 0;
        while (u_checker.rx_cnt == snap_rx && u_checker.ferr_cnt == snap_fe
               && n < 4 * bit_clks) begin
            tick();
            n++;
        end
        if (u_checker.rx_cnt == snap_rx && u_checker.ferr_cnt == snap_fe) begin
            $display("timeout: no byte_ready or framing_error in test %s", name);
            abort = 1'b1;
        end else begin
            // an idle bit catches a stray second pulse
            repeat (bit_clks) tick();
            u_checker.check_rx(name, good, exp_data, exp_st, exp_nr, snap_rx, snap_fe);
        end
    endtask

    task automatic send_byte(input string name, input logic [7:0] b, input bit extra);
        int snap_tx;
        int snap_busy;
        int n;
        snap_tx = u_checker.tx_cnt;
        snap_busy = u_checker.busy_cnt;
        midi_out_data = b;
        midi_send_byte = 1'b1;
        tick();
        midi_send_byte = 1'b0;
        if (extra) begin
            // strobe in the middle of the frame must be dropped
            repeat (3 * bit_clks) tick();
            midi_out_data = ~b;
            midi_send_byte = 1'b1;
            tick();
            midi_send_byte = 1'b0;
        end
        n = 0;
        while (u_checker.busy_cnt == snap_busy && n < 12 * bit_clks) begin
            tick();
            n++;
        end
        if (u_checker.busy_cnt == snap_busy) begin
            $display("timeout: midi_out_ready did not return high in test %s", name);
            abort = 1'b1;
        end else begin
            if (extra) begin
                repeat (12 * bit_clks) tick();
            end
            u_checker.check_tx(name, b, snap_tx, snap_busy);
        end
    endtask

    task automatic run_roundtrip(input string name, input int count);
        int         i;
        logic [7:0] b;
        logic [7:0] echo;
        for (i = 0; i < count && !abort; i++) begin
            b = 8'($random(seed));
            send_byte(name, b, 1'b0);
            if (!abort) begin
                echo = u_checker.tx_frame[8:1];
                // running status rule for the tracker
                if (b[7] && b != 8'hf7) begin
                    model_st = b;
                    model_nr = 8'd0;
                end else begin
                    model_nr = model_nr + 8'd1;
                end
                last_rx = b;
                recv_byte(name, echo, 1'b1, b, model_st, model_nr);
            end
        end
    endtask

    initial begin
        string      line;
        string      name;
        string      mode;
        logic [7:0] vbyte;
        logic [7:0] vst;
        logic [7:0] vnr;
        int         fd;
        int         n;
        midi_rxd = 1'b1;
        midi_send_byte = 1'b0;
        midi_out_data = 8'd0;
        abort = 1'b0;
        seed = 25349;
        last_rx = 8'd0;
        model_st = 8'd0;
        model_nr = 8'd0;
        fd = 0;

        tick();
        n = 0;
        while (!reset_mid_n && n < 40) begin
            tick();
            n++;
        end
        if (!reset_mid_n) begin
            $display("timeout: reset_mid_n never went high");
            abort = 1'b1;
        end else begin
            repeat (4) tick();
            u_checker.check_reset();
            u_checker.end_test("reset");
            fd = $fopen("tb/midi_input_vectors.txt", "r");
            if (fd == 0) begin
                $display("could not open tb/midi_input_vectors.txt");
                abort = 1'b1;
            end
        end

        while (!abort && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%s %s %h %h %h", name, mode, vbyte, vst, vnr) != 5) begin
                $display("malformed vector line: %s", line);
                abort = 1'b1;
            end else if (mode == "rx") begin
                last_rx = vbyte;
                model_st = vst;
                model_nr = vnr;
                recv_byte(name, vbyte, 1'b1, vbyte, vst, vnr);
            end else if (mode == "rxbad") begin
                recv_byte(name, vbyte, 1'b0, last_rx, vst, vnr);
            end else if (mode == "tx") begin
                send_byte(name, vbyte, 1'b1);
            end else if (mode == "loop") begin
                run_roundtrip(name, int'(vbyte));
            end else begin
                $display("unknown mode %s in vector %s", mode, name);
                abort = 1'b1;
            end
            if (!abort) begin
                u_checker.end_test(name);
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        u_checker.report();
        if (abort || u_checker.fail_cnt != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/midi_uart_checker.sv
`timescale 1ns/1ns
`default_nettype none

module midi_uart_checker (
    input wire       midi_clk,
    input wire       reset_mid_n,
    input wire       byte_ready,
    input wire [7:0] midi_in_data,
    input wire       framing_error,
    input wire [7:0] cur_status,
    input wire [7:0] midibyte_nr,
    input wire       midi_txd,
    input wire       midi_out_ready
);

    localparam int clks = midi_timing_pkg::clks_per_bit;

    int         pass_cnt;
    int         fail_cnt;
    int         test_errs;
    int         rx_cnt;
    int         ferr_cnt;
    int         tx_cnt;
    int         busy_cnt;
    int         busy_run;
    int         busy_len;
    int         dec_pos;
    bit         ready_d;
    bit         txd_prev;
    bit         dec_active;
    logic [3:0] dec_idx;
    logic [7:0] rx_data;
    logic [7:0] rx_status;
    logic [7:0] rx_nr;
    logic [9:0] dec_bits;
    logic [9:0] tx_frame;

    always @(posedge midi_clk) begin
        if (reset_mid_n) begin
            // tracker outputs one cycle after byte_ready
            if (ready_d) begin
                rx_status = cur_status;
                rx_nr     = midibyte_nr;
                rx_cnt++;
            end
            ready_d = byte_ready;
            if (byte_ready) begin
                rx_data = midi_in_data;
            end
            if (framing_error) begin
                ferr_cnt++;
            end

            if (!midi_out_ready) begin
                busy_run++;
            end else if (busy_run != 0) begin
                busy_len = busy_run;
                busy_run = 0;
                busy_cnt++;
            end

            // sample each txd bit at its middle
            if (dec_active) begin
                dec_pos++;
                if (dec_pos % clks == midi_timing_pkg::half_bit) begin
                    dec_idx = 4'(dec_pos / clks);
                    dec_bits[dec_idx] = midi_txd;
                    if (dec_idx == 4'd9) begin
                        tx_frame   = dec_bits;
                        dec_active = 1'b0;
                        tx_cnt++;
                    end
                end
            end else if (txd_prev && !midi_txd) begin
                dec_active = 1'b1;
                dec_pos    = 0;
            end
            txd_prev = midi_txd;
        end
    end

    task automatic compare(input string name, input string what,
                           input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s %s expected %h actual %h", name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_reset();
        compare("reset", "midi_txd", 8'd1, 8'(midi_txd));
        compare("reset", "midi_out_ready", 8'd1, 8'(midi_out_ready));
        compare("reset", "byte_ready pulses", 8'd0, 8'(rx_cnt));
        compare("reset", "framing_error pulses", 8'd0, 8'(ferr_cnt));
        compare("reset", "cur_status", 8'd0, cur_status);
        compare("reset", "midibyte_nr", 8'd0, midibyte_nr);
        compare("reset", "midi_in_data", 8'd0, midi_in_data);
    endtask

    task automatic check_rx(input string name, input bit good, input logic [7:0] exp_data,
                            input logic [7:0] exp_st, input logic [7:0] exp_nr,
                            input int snap_rx, input int snap_fe);
        compare(name, "byte_ready pulses", good ? 8'd1 : 8'd0, 8'(rx_cnt - snap_rx));
        compare(name, "framing_error pulses", good ? 8'd0 : 8'd1, 8'(ferr_cnt - snap_fe));
        compare(name, "midi_in_data", exp_data, midi_in_data);
        if (good) begin
            compare(name, "midi_in_data at byte_ready", exp_data, rx_data);
            compare(name, "cur_status", exp_st, rx_status);
            compare(name, "midibyte_nr", exp_nr, rx_nr);
        end else begin
            compare(name, "cur_status", exp_st, cur_status);
            compare(name, "midibyte_nr", exp_nr, midibyte_nr);
        end
    endtask

    task automatic check_tx(input string name, input logic [7:0] exp_byte,
                            input int snap_tx, input int snap_busy);
        compare(name, "txd frames", 8'd1, 8'(tx_cnt - snap_tx));
        compare(name, "busy periods", 8'd1, 8'(busy_cnt - snap_busy));
        compare(name, "busy cycles", 8'(10 * clks), 8'(busy_len));
        compare(name, "start bit", 8'd0, 8'(tx_frame[0]));
        compare(name, "txd data", exp_byte, tx_frame[8:1]);
        compare(name, "stop bit", 8'd1, 8'(tx_frame[9]));
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic report();
        $display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    endtask

endmodule

`default_nettype wire

//--- tb/midi_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module midi_clk_gen (
    output logic midi_clk,
    output logic reset_mid_n
);

    localparam int half_period_ns = 5;
    localparam int reset_cycles = 10;

    initial begin
        midi_clk = 1'b0;
        forever #(half_period_ns) midi_clk = ~midi_clk;
    end

    // released 1 ns after an edge like the other inputs
    initial begin
        reset_mid_n = 1'b0;
        repeat (reset_cycles) @(posedge midi_clk);
        #1;
        reset_mid_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/midi_uart_top.sv
`timescale 1ns/1ns
`default_nettype none

module midi_uart_top (
    input  wire        midi_clk,
    input  wire        reset_mid_n,
    input  wire        midi_rxd,
    output wire        byte_ready,
    output wire  [7:0] midi_in_data,
    output wire        framing_error,
    output wire  [7:0] cur_status,
    output wire  [7:0] midibyte_nr,
    input  wire        midi_send_byte,
    input  wire  [7:0] midi_out_data,
    output wire        midi_txd,
    output wire        midi_out_ready
);

    midi_bit_if rx_bit ();
    midi_bit_if tx_bit ();

    midi_bit_timer u_rx_timer (
        .midi_clk    (midi_clk),
        .reset_mid_n (reset_mid_n),
        .bif         (rx_bit.timer)
    );

    midi_rx_frame u_rx_frame (
        .midi_clk      (midi_clk),
        .reset_mid_n   (reset_mid_n),
        .midi_rxd      (midi_rxd),
        .bif           (rx_bit.frame),
        .byte_ready    (byte_ready),
        .rx_byte       (midi_in_data),
        .framing_error (framing_error)
    );

    midi_status_tracker u_status_tracker (
        .midi_clk    (midi_clk),
        .reset_mid_n (reset_mid_n),
        .byte_ready  (byte_ready),
        .rx_byte     (midi_in_data),
        .cur_status  (cur_status),
        .midibyte_nr (midibyte_nr)
    );

    midi_bit_timer u_tx_timer (
        .midi_clk    (midi_clk),
        .reset_mid_n (reset_mid_n),
        .bif         (tx_bit.timer)
    );

    midi_tx_frame u_tx_frame (
        .midi_clk       (midi_clk),
        .reset_mid_n    (reset_mid_n),
        .midi_send_byte (midi_send_byte),
        .midi_out_data  (midi_out_data),
        .bif            (tx_bit.frame),
        .midi_txd       (midi_txd),
        .midi_out_ready (midi_out_ready)
    );

endmodule

`default_nettype wire

//--- hdl/midi_tx_frame.sv
`timescale 1ns/1ns
`default_nettype none

module midi_tx_frame (
    input  wire        midi_clk,
    input  wire        reset_mid_n,
    input  wire        midi_send_byte,
    input  wire  [7:0] midi_out_data,
    midi_bit_if.frame  bif,
    output logic       midi_txd,
    output logic       midi_out_ready
);

    midi_proto_pkg::tx_state_e state;

    logic       accept;
    logic [2:0] bit_idx;
    logic [7:0] shreg;

    // strobes while busy are dropped
    assign accept = state == midi_proto_pkg::tx_idle && midi_out_ready && midi_send_byte;

    assign bif.run     = state != midi_proto_pkg::tx_idle;
    assign bif.restart = accept;

    always_ff @(posedge midi_clk or negedge reset_mid_n) begin
        if (!reset_mid_n) begin
            state          <= midi_proto_pkg::tx_idle;
            bit_idx        <= '0;
            midi_txd       <= 1'b1;
            midi_out_ready <= 1'b1;
        end else begin
            case (state)
                midi_proto_pkg::tx_idle: begin
                    if (accept) begin
                        state          <= midi_proto_pkg::tx_start;
                        midi_txd       <= 1'b0;
                        midi_out_ready <= 1'b0;
                    end
                end
                midi_proto_pkg::tx_start: begin
                    if (bif.bit_tick) begin
                        state    <= midi_proto_pkg::tx_data;
                        bit_idx  <= '0;
                        midi_txd <= shreg[0];
                    end
                end
                midi_proto_pkg::tx_data: begin
                    if (bif.bit_tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'(midi_timing_pkg::data_bits - 1)) begin
                            state    <= midi_proto_pkg::tx_stop;
                            midi_txd <= 1'b1;
                        end else begin
                            midi_txd <= shreg[0];
                        end
                    end
                end
                default: begin
                    // the line stays high after the stop bit
                    if (bif.bit_tick) begin
                        state          <= midi_proto_pkg::tx_idle;
                        midi_out_ready <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge midi_clk) begin
        if (accept) begin
            shreg <= midi_out_data;
        end else if (bif.bit_tick && state != midi_proto_pkg::tx_idle) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- hdl/midi_status_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module midi_status_tracker (
    input  wire        midi_clk,
    input  wire        reset_mid_n,
    input  wire        byte_ready,
    input  wire  [7:0] rx_byte,
    output logic [7:0] cur_status,
    output logic [7:0] midibyte_nr
);

    midi_proto_pkg::byte_class_e byte_class;

    always_comb begin
        if (!rx_byte[7]) begin
            byte_class = midi_proto_pkg::class_data;
        end else if (rx_byte == midi_proto_pkg::sysex_end_byte) begin
            byte_class = midi_proto_pkg::class_sysex_end;
        end else begin
            byte_class = midi_proto_pkg::class_status;
        end
    end

    // byte number wraps at 8 bits
    always_ff @(posedge midi_clk or negedge reset_mid_n) begin
        if (!reset_mid_n) begin
            cur_status  <= '0;
            midibyte_nr <= '0;
        end else if (byte_ready) begin
            if (byte_class == midi_proto_pkg::class_status) begin
                cur_status  <= rx_byte;
                midibyte_nr <= '0;
            end else begin
                midibyte_nr <= midibyte_nr + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/midi_rx_frame.sv
`timescale 1ns/1ns
`default_nettype none

module midi_rx_frame (
    input  wire        midi_clk,
    input  wire        reset_mid_n,
    input  wire        midi_rxd,
    midi_bit_if.frame  bif,
    output logic       byte_ready,
    output logic [7:0] rx_byte,
    output logic       framing_error
);

    midi_proto_pkg::rx_state_e state;

    logic       rxd_meta;
    logic       rxd_sync;
    logic       rxd_prev;
    logic       fall;
    logic [2:0] bit_idx;
    logic [7:0] shreg;

    // line idles high
    always_ff @(posedge midi_clk or negedge reset_mid_n) begin
        if (!reset_mid_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= midi_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall = rxd_prev && !rxd_sync;

    assign bif.run     = state != midi_proto_pkg::rx_idle;
    assign bif.restart = state == midi_proto_pkg::rx_idle && fall;

    always_ff @(posedge midi_clk or negedge reset_mid_n) begin
        if (!reset_mid_n) begin
            state         <= midi_proto_pkg::rx_idle;
            bit_idx       <= '0;
            byte_ready    <= 1'b0;
            framing_error <= 1'b0;
            rx_byte       <= '0;
        end else begin
            byte_ready    <= 1'b0;
            framing_error <= 1'b0;
            case (state)
                midi_proto_pkg::rx_idle: begin
                    if (fall) begin
                        state <= midi_proto_pkg::rx_start;
                    end
                end
                midi_proto_pkg::rx_start: begin
                    // a high line at mid-bit was only a glitch
                    if (bif.mid_tick) begin
                        state   <= rxd_sync ? midi_proto_pkg::rx_idle : midi_proto_pkg::rx_data;
                        bit_idx <= '0;
                    end
                end
                midi_proto_pkg::rx_data: begin
                    if (bif.mid_tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'(midi_timing_pkg::data_bits - 1)) begin
                            state <= midi_proto_pkg::rx_stop;
                        end
                    end
                end
                default: begin
                    if (bif.mid_tick) begin
                        state <= midi_proto_pkg::rx_idle;
                        if (rxd_sync) begin
                            byte_ready <= 1'b1;
                            rx_byte    <= shreg;
                        end else begin
                            framing_error <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge midi_clk) begin
        if (state == midi_proto_pkg::rx_data && bif.mid_tick) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- hdl/midi_bit_timer.sv
`timescale 1ns/1ns
`default_nettype none

module midi_bit_timer (
    input  wire        midi_clk,
    input  wire        reset_mid_n,
    midi_bit_if.timer  bif
);

    midi_timing_pkg::bit_cnt_t cnt;
    logic                      at_mid;
    logic                      at_last;

    assign at_mid  = cnt == midi_timing_pkg::bit_cnt_t'(midi_timing_pkg::half_bit);
    assign at_last = cnt == midi_timing_pkg::bit_cnt_t'(midi_timing_pkg::clks_per_bit - 1);

    always_ff @(posedge midi_clk or negedge reset_mid_n) begin
        if (!reset_mid_n) begin
            cnt <= '0;
        end else if (bif.restart || !bif.run) begin
            cnt <= '0;
        end else if (at_last) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ticks only while the frame fsm keeps us running
    assign bif.mid_tick = bif.run && at_mid;
    assign bif.bit_tick = bif.run && at_last;

endmodule

`default_nettype wire

//--- hdl/midi_bit_if.sv
`timescale 1ns/1ns
`default_nettype none

interface midi_bit_if;

    // from the frame fsm
    logic run;
    logic restart;

    // from the timer
    logic mid_tick;
    logic bit_tick;

    modport timer (
        input  run,
        input  restart,
        output mid_tick,
        output bit_tick
    );

    modport frame (
        output run,
        output restart,
        input  mid_tick,
        input  bit_tick
    );

endinterface

`default_nettype wire

//--- hdl/midi_proto_pkg.sv
`default_nettype none

package midi_proto_pkg;

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

    // F7 ends sysex but counts like a data byte
    typedef enum logic [1:0] {
        class_data,
        class_status,
        class_sysex_end
    } byte_class_e;

    localparam logic [7:0] sysex_end_byte = 8'hf7;

endpackage

`default_nettype wire

//--- hdl/midi_timing_pkg.sv
`default_nettype none

package midi_timing_pkg;

    // 500 kHz midi_clk over 31250 baud
    localparam int unsigned clks_per_bit = 16;
    localparam int unsigned half_bit = clks_per_bit / 2;

    localparam int unsigned data_bits = 8;

    localparam int unsigned bit_cnt_w = $clog2(clks_per_bit);

    typedef logic [bit_cnt_w-1:0] bit_cnt_t;

endpackage

`default_nettype wire
